//--- logic/delay_pkg.sv
package delay_pkg;

   // fifo depth is 2**DEF_ADDR_W, the widest amount is one less
   localparam int DEF_ADDR_W = 7;
   localparam int DEF_DATA_W = 32;

   // one bit above the register map so that offsets from 0x10 up decode as errors
   localparam int AXIL_ADDR_W = 5;

   // register byte offsets
   localparam logic [AXIL_ADDR_W-1:0] REG_CONTROL = 'h0;
   localparam logic [AXIL_ADDR_W-1:0] REG_AMOUNT  = 'h4;
   localparam logic [AXIL_ADDR_W-1:0] REG_LENGTH  = 'h8;
   localparam logic [AXIL_ADDR_W-1:0] REG_STATUS  = 'hC;

   // control register, write-only start request
   localparam int CTRL_START_BIT = 0;

   // status register bits
   localparam int STATUS_BUSY_BIT = 0;
   localparam int STATUS_DONE_BIT = 1;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_FLUSH,
      SEQ_RUN,
      SEQ_DONE
   } seq_state_t;

endpackage

//--- logic/ram_port_if.sv
interface ram_port_if #(
   parameter int ADDR_W = delay_pkg::DEF_ADDR_W,
   parameter int DATA_W = delay_pkg::DEF_DATA_W
);

   logic              w_en;
   logic [ADDR_W-1:0] w_addr;
   logic [DATA_W-1:0] w_data;
   logic              r_en;
   logic [ADDR_W-1:0] r_addr;
   // valid one cycle after r_en
   logic [DATA_W-1:0] r_data;

   modport fifo (output w_en, w_addr, w_data, r_en, r_addr, input r_data);

   modport ram (input w_en, w_addr, w_data, r_en, r_addr, output r_data);

endinterface

//--- logic/dual_port_ram.sv
module dual_port_ram #(
   parameter int ADDR_W = delay_pkg::DEF_ADDR_W,
   parameter int DATA_W = delay_pkg::DEF_DATA_W
) (
   input logic clk,
   ram_port_if.ram mem
);

   logic [DATA_W-1:0] ram_q [0:2**ADDR_W-1];

   // write port
   always_ff @(posedge clk) begin
      if (mem.w_en) begin
         ram_q[mem.w_addr] <= mem.w_data;
      end
   end

   // registered read port, old data on an address collision
   always_ff @(posedge clk) begin
      if (mem.r_en) begin
         mem.r_data <= ram_q[mem.r_addr];
      end
   end

endmodule

//--- logic/sync_fifo.sv
module sync_fifo #(
   parameter int ADDR_W = delay_pkg::DEF_ADDR_W,
   parameter int DATA_W = delay_pkg::DEF_DATA_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              flush_i,
   input  logic              w_en_i,
   input  logic [DATA_W-1:0] w_data_i,
   input  logic              r_en_i,
   output logic [DATA_W-1:0] r_data_o,
   output logic [  ADDR_W:0] level_o,
   ram_port_if.fifo          mem
);

   logic [ADDR_W-1:0] w_ptr_q;
   logic [ADDR_W-1:0] r_ptr_q;
   logic [  ADDR_W:0] level_q;
   logic              full;
   logic              empty;
   logic              do_write;
   logic              do_read;

   // level only reaches 2**ADDR_W when full
   assign full  = level_q[ADDR_W];
   assign empty = (level_q == '0);

   // a simultaneous read lets a full fifo take a write, and the reverse
   assign do_write = w_en_i && (!full || r_en_i);
   assign do_read  = r_en_i && (!empty || w_en_i);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else if (flush_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (do_write) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (do_read) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   assign mem.w_en   = do_write;
   assign mem.w_addr = w_ptr_q;
   assign mem.w_data = w_data_i;
   assign mem.r_en   = do_read;
   assign mem.r_addr = r_ptr_q;

   // ram read port is registered, data lands one cycle after r_en_i
   assign r_data_o = mem.r_data;
   assign level_o  = level_q;

endmodule

//--- logic/run_counter.sv
module run_counter #(
   parameter int LENGTH_W = 16
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                load_i,
   input  logic [LENGTH_W-1:0] length_i,
   input  logic                count_en_i,
   output logic                last_o
);

   // samples left in the current run
   logic [LENGTH_W-1:0] count_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_q <= '0;
      end else if (load_i) begin
         count_q <= length_i;
      end else if (count_en_i && (count_q != '0)) begin
         count_q <= count_q - 1'b1;
      end
   end

   // one sample left means this is the final cycle
   assign last_o = (count_q == LENGTH_W'(1));

endmodule

//--- logic/run_sequencer.sv
module run_sequencer (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start_i,
   input  logic                  last_i,
   input  logic                  length_zero_i,
   output logic                  flush_o,
   output logic                  load_o,
   output logic                  running_o,
   output logic                  done_o,
   output logic                  busy_o,
   output delay_pkg::seq_state_t state_o
);

   delay_pkg::seq_state_t state_q;
   delay_pkg::seq_state_t state_d;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= delay_pkg::SEQ_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         delay_pkg::SEQ_IDLE: begin
            if (start_i) begin
               state_d = delay_pkg::SEQ_FLUSH;
            end
         end
         delay_pkg::SEQ_FLUSH: begin
            // an empty run skips straight to done
            if (length_zero_i) begin
               state_d = delay_pkg::SEQ_DONE;
            end else begin
               state_d = delay_pkg::SEQ_RUN;
            end
         end
         delay_pkg::SEQ_RUN: begin
            if (last_i) begin
               state_d = delay_pkg::SEQ_DONE;
            end
         end
         delay_pkg::SEQ_DONE: begin
            state_d = delay_pkg::SEQ_IDLE;
         end
         default: begin
            state_d = delay_pkg::SEQ_IDLE;
         end
      endcase
   end

   // flush clears the fifo while the counter loads
   assign flush_o   = (state_q == delay_pkg::SEQ_FLUSH);
   assign load_o    = (state_q == delay_pkg::SEQ_FLUSH);
   assign running_o = (state_q == delay_pkg::SEQ_RUN);
   assign done_o    = (state_q == delay_pkg::SEQ_DONE);
   assign busy_o    = (state_q != delay_pkg::SEQ_IDLE);
   assign state_o   = state_q;

endmodule

//--- logic/delay_buffer.sv
module delay_buffer #(
   parameter int ADDR_W = delay_pkg::DEF_ADDR_W,
   parameter int DATA_W = delay_pkg::DEF_DATA_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              flush_i,
   input  logic              running_i,
   input  logic [DATA_W-1:0] data_i,
   input  logic [ADDR_W-1:0] amount_i,
   output logic [DATA_W-1:0] data_o,
   output logic              valid_o
);

   logic [  ADDR_W:0] level;
   logic [  ADDR_W:0] amount_ext;
   logic              wr_en;
   logic              rd_en;
   logic [DATA_W-1:0] fifo_data;
   logic [DATA_W-1:0] data_q;

   ram_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_if ();

   assign amount_ext = {1'b0, amount_i};

   // fill up to the amount, then every sample writes one and reads one
   assign wr_en = running_i && (level <= amount_ext);
   assign rd_en = running_i && (level >= amount_ext);

   sync_fifo #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_fifo (
      .clk     (clk),
      .rst     (rst),
      .flush_i (flush_i),
      .w_en_i  (wr_en),
      .w_data_i(data_i),
      .r_en_i  (rd_en),
      .r_data_o(fifo_data),
      .level_o (level),
      .mem     (mem_if.fifo)
   );

   dual_port_ram #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_ram (
      .clk(clk),
      .mem(mem_if.ram)
   );

   // zero delay path, one register stage
   always_ff @(posedge clk) begin
      data_q <= data_i;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= rd_en;
      end
   end

   assign data_o = (amount_i == '0) ? data_q : fifo_data;

endmodule

//--- logic/axil_config_regs.sv
module axil_config_regs #(
   parameter int DATA_W   = delay_pkg::DEF_DATA_W,
   parameter int LENGTH_W = 16,
   parameter int ADDR_W   = delay_pkg::DEF_ADDR_W
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [delay_pkg::AXIL_ADDR_W-1:0] awaddr_i,
   input  logic                              awvalid_i,
   output logic                              awready_o,
   input  logic [DATA_W-1:0]                 wdata_i,
   input  logic [DATA_W/8-1:0]               wstrb_i,
   input  logic                              wvalid_i,
   output logic                              wready_o,
   output logic [1:0]                        bresp_o,
   output logic                              bvalid_o,
   input  logic                              bready_i,
   input  logic [delay_pkg::AXIL_ADDR_W-1:0] araddr_i,
   input  logic                              arvalid_i,
   output logic                              arready_o,
   output logic [DATA_W-1:0]                 rdata_o,
   output logic [1:0]                        rresp_o,
   output logic                              rvalid_o,
   input  logic                              rready_i,
   input  logic                              busy_i,
   input  logic                              done_i,
   output logic                              start_o,
   output logic [ADDR_W-1:0]                 amount_o,
   output logic [LENGTH_W-1:0]               length_o
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic [ADDR_W-1:0]   amount_q;
   logic [LENGTH_W-1:0] length_q;
   logic                done_q;
   logic                wr_hs;
   logic                rd_hs;
   logic [DATA_W-1:0]   wmask;
   logic [DATA_W-1:0]   amount_wr;
   logic [DATA_W-1:0]   length_wr;
   logic [DATA_W-1:0]   rd_value;

   function automatic logic reg_hit(input logic [delay_pkg::AXIL_ADDR_W-1:0] addr);
      return addr inside {delay_pkg::REG_CONTROL, delay_pkg::REG_AMOUNT,
                          delay_pkg::REG_LENGTH, delay_pkg::REG_STATUS};
   endfunction

   assign wr_hs = awready_o && awvalid_i && wvalid_i;
   assign rd_hs = arready_o && arvalid_i;

   // byte lanes from the write strobe
   always_comb begin
      for (int i = 0; i < DATA_W / 8; i++) begin
         wmask[i*8+:8] = {8{wstrb_i[i]}};
      end
   end

   assign amount_wr = (DATA_W'(amount_q) & ~wmask) | (wdata_i & wmask);
   assign length_wr = (DATA_W'(length_q) & ~wmask) | (wdata_i & wmask);

   // start only counts when the sequencer is idle
   assign start_o = wr_hs && !busy_i && (awaddr_i == delay_pkg::REG_CONTROL) &&
                    wdata_i[delay_pkg::CTRL_START_BIT] &&
                    wstrb_i[delay_pkg::CTRL_START_BIT/8];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
         bresp_o   <= RESP_OKAY;
         amount_q  <= '0;
         length_q  <= '0;
         done_q    <= 1'b0;
      end else begin
         // one-cycle ready pulse, held off while a response waits
         awready_o <= awvalid_i && wvalid_i && !bvalid_o && !awready_o;
         wready_o  <= awvalid_i && wvalid_i && !bvalid_o && !awready_o;
         if (wr_hs) begin
            bvalid_o <= 1'b1;
            bresp_o  <= reg_hit(awaddr_i) ? RESP_OKAY : RESP_SLVERR;
            if (!busy_i && (awaddr_i == delay_pkg::REG_AMOUNT)) begin
               amount_q <= amount_wr[ADDR_W-1:0];
            end
            if (!busy_i && (awaddr_i == delay_pkg::REG_LENGTH)) begin
               length_q <= length_wr[LENGTH_W-1:0];
            end
         end else if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
         end
         if (start_o) begin
            done_q <= 1'b0;
         end else if (done_i) begin
            done_q <= 1'b1;
         end
      end
   end

   always_comb begin
      rd_value = '0;
      case (araddr_i)
         delay_pkg::REG_AMOUNT: rd_value = DATA_W'(amount_q);
         delay_pkg::REG_LENGTH: rd_value = DATA_W'(length_q);
         delay_pkg::REG_STATUS: begin
            rd_value[delay_pkg::STATUS_BUSY_BIT] = busy_i;
            rd_value[delay_pkg::STATUS_DONE_BIT] = done_q;
         end
         // control reads as zero, unmapped as well
         default: rd_value = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
      end else begin
         arready_o <= arvalid_i && !rvalid_o && !arready_o;
         if (rd_hs) begin
            rvalid_o <= 1'b1;
         end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
         end
      end
   end

   // read payload, held until rready
   always_ff @(posedge clk) begin
      if (rd_hs) begin
         rdata_o <= rd_value;
         rresp_o <= reg_hit(araddr_i) ? RESP_OKAY : RESP_SLVERR;
      end
   end

   assign amount_o = amount_q;
   assign length_o = length_q;

endmodule

//--- logic/delay_unit_top.sv
module delay_unit_top #(
   parameter int ADDR_W   = delay_pkg::DEF_ADDR_W,
   parameter int DATA_W   = delay_pkg::DEF_DATA_W,
   parameter int LENGTH_W = 16
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [delay_pkg::AXIL_ADDR_W-1:0] awaddr_i,
   input  logic                              awvalid_i,
   output logic                              awready_o,
   input  logic [DATA_W-1:0]                 wdata_i,
   input  logic [DATA_W/8-1:0]               wstrb_i,
   input  logic                              wvalid_i,
   output logic                              wready_o,
   output logic [1:0]                        bresp_o,
   output logic                              bvalid_o,
   input  logic                              bready_i,
   input  logic [delay_pkg::AXIL_ADDR_W-1:0] araddr_i,
   input  logic                              arvalid_i,
   output logic                              arready_o,
   output logic [DATA_W-1:0]                 rdata_o,
   output logic [1:0]                        rresp_o,
   output logic                              rvalid_o,
   input  logic                              rready_i,
   input  logic [DATA_W-1:0]                 stream_data_i,
   output logic                              stream_ready_o,
   output logic [DATA_W-1:0]                 stream_data_o,
   output logic                              stream_valid_o,
   output delay_pkg::seq_state_t             state_o
);

   logic                start;
   logic                busy;
   logic                done;
   logic                flush;
   logic                load;
   logic                running;
   logic                last;
   logic                length_zero;
   logic [ADDR_W-1:0]   amount;
   logic [LENGTH_W-1:0] length;

   assign length_zero = (length == '0);

   axil_config_regs #(
      .DATA_W  (DATA_W),
      .LENGTH_W(LENGTH_W),
      .ADDR_W  (ADDR_W)
   ) u_regs (
      .clk      (clk),
      .rst      (rst),
      .awaddr_i (awaddr_i),
      .awvalid_i(awvalid_i),
      .awready_o(awready_o),
      .wdata_i  (wdata_i),
      .wstrb_i  (wstrb_i),
      .wvalid_i (wvalid_i),
      .wready_o (wready_o),
      .bresp_o  (bresp_o),
      .bvalid_o (bvalid_o),
      .bready_i (bready_i),
      .araddr_i (araddr_i),
      .arvalid_i(arvalid_i),
      .arready_o(arready_o),
      .rdata_o  (rdata_o),
      .rresp_o  (rresp_o),
      .rvalid_o (rvalid_o),
      .rready_i (rready_i),
      .busy_i   (busy),
      .done_i   (done),
      .start_o  (start),
      .amount_o (amount),
      .length_o (length)
   );

   run_sequencer u_seq (
      .clk          (clk),
      .rst          (rst),
      .start_i      (start),
      .last_i       (last),
      .length_zero_i(length_zero),
      .flush_o      (flush),
      .load_o       (load),
      .running_o    (running),
      .done_o       (done),
      .busy_o       (busy),
      .state_o      (state_o)
   );

   run_counter #(
      .LENGTH_W(LENGTH_W)
   ) u_counter (
      .clk       (clk),
      .rst       (rst),
      .load_i    (load),
      .length_i  (length),
      .count_en_i(running),
      .last_o    (last)
   );

   delay_buffer #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_buffer (
      .clk      (clk),
      .rst      (rst),
      .flush_i  (flush),
      .running_i(running),
      .data_i   (stream_data_i),
      .amount_i (amount),
      .data_o   (stream_data_o),
      .valid_o  (stream_valid_o)
   );

   // a sample is taken on every running cycle
   assign stream_ready_o = running;

endmodule

//--- verification/delay_unit_tb_axil.svh
// AXI4-Lite master tasks
// inputs change 1 unit after the rising edge and outputs are sampled on the falling edge

function automatic void report_unstable(input string channel);
   protocol_errors++;
   $display("The %s response changed or dropped before it was accepted", channel);
endfunction

task automatic axil_write(input logic [AW-1:0] addr, input logic [DATA_W-1:0] data,
                          output logic [1:0] resp);
   int hold;
   @(posedge clk);
   #1;
   awaddr_i  = addr;
   awvalid_i = 1'b1;
   wdata_i   = data;
   wstrb_i   = '1;
   wvalid_i  = 1'b1;
   @(negedge clk);
   while (!awready_o) @(negedge clk);
   if (!wready_o) begin
      protocol_errors++;
      $display("The write data channel was not ready together with the address channel");
   end
   // handshake on the coming edge
   @(posedge clk);
   #1;
   awvalid_i = 1'b0;
   wvalid_i  = 1'b0;
   @(negedge clk);
   while (!bvalid_o) @(negedge clk);
   resp = bresp_o;
   // response must hold under back-pressure
   hold = {$random(seed)} % 4;
   repeat (hold) begin
      @(negedge clk);
      if (!bvalid_o || bresp_o !== resp)
         report_unstable("write");
   end
   @(posedge clk);
   #1;
   bready_i = 1'b1;
   @(negedge clk);
   if (!bvalid_o || bresp_o !== resp)
      report_unstable("write");
   @(posedge clk);
   #1;
   bready_i = 1'b0;
   @(negedge clk);
   if (bvalid_o) begin
      protocol_errors++;
      $display("A write response was still pending after it had been accepted");
   end
endtask

task automatic axil_read(input logic [AW-1:0] addr, output logic [DATA_W-1:0] data,
                         output logic [1:0] resp);
   int hold;
   @(posedge clk);
   #1;
   araddr_i  = addr;
   arvalid_i = 1'b1;
   @(negedge clk);
   while (!arready_o) @(negedge clk);
   @(posedge clk);
   #1;
   arvalid_i = 1'b0;
   @(negedge clk);
   while (!rvalid_o) @(negedge clk);
   data = rdata_o;
   resp = rresp_o;
   hold = {$random(seed)} % 4;
   repeat (hold) begin
      @(negedge clk);
      if (!rvalid_o || rdata_o !== data || rresp_o !== resp)
         report_unstable("read");
   end
   @(posedge clk);
   #1;
   rready_i = 1'b1;
   @(negedge clk);
   if (!rvalid_o || rdata_o !== data || rresp_o !== resp)
      report_unstable("read");
   @(posedge clk);
   #1;
   rready_i = 1'b0;
   @(negedge clk);
   if (rvalid_o) begin
      protocol_errors++;
      $display("A read response was still pending after it had been accepted");
   end
endtask

//--- verification/delay_unit_tb.sv
module delay_unit_tb;

   localparam int ADDR_W   = delay_pkg::DEF_ADDR_W;
   localparam int DATA_W   = delay_pkg::DEF_DATA_W;
   localparam int LENGTH_W = 16;
   localparam int AW       = delay_pkg::AXIL_ADDR_W;
   localparam logic [1:0] OKAY   = 2'b00;
   localparam logic [1:0] SLVERR = 2'b10;

   logic                  clk;
   logic                  rst;
   logic [AW-1:0]         awaddr_i;
   logic                  awvalid_i;
   logic                  awready_o;
   logic [DATA_W-1:0]     wdata_i;
   logic [DATA_W/8-1:0]   wstrb_i;
   logic                  wvalid_i;
   logic                  wready_o;
   logic [1:0]            bresp_o;
   logic                  bvalid_o;
   logic                  bready_i;
   logic [AW-1:0]         araddr_i;
   logic                  arvalid_i;
   logic                  arready_o;
   logic [DATA_W-1:0]     rdata_o;
   logic [1:0]            rresp_o;
   logic                  rvalid_o;
   logic                  rready_i;
   logic [DATA_W-1:0]     stream_data_i;
   logic                  stream_ready_o;
   logic [DATA_W-1:0]     stream_data_o;
   logic                  stream_valid_o;
   delay_pkg::seq_state_t state_o;

   integer            seed;
   int                error_count;
   int                protocol_errors;
   int                sample_budget;
   int                cycle;
   int                done_count;
   int                done_before;
   logic [DATA_W-1:0] in_q[$];
   logic [DATA_W-1:0] out_q[$];
   int                in_cyc[$];
   int                out_cyc[$];
   logic [DATA_W-1:0] rd_data;
   logic [1:0]        resp;

   `include "delay_unit_tb_axil.svh"

   delay_unit_top #(
      .ADDR_W  (ADDR_W),
      .DATA_W  (DATA_W),
      .LENGTH_W(LENGTH_W)
   ) DUT (.*);

   always #4 clk = ~clk;

   // new random sample every cycle
   always @(posedge clk) begin
      #1;
      stream_data_i = $random(seed);
   end

   // model capture on the falling edge
   always @(negedge clk) begin
      cycle++;
      if (stream_ready_o) begin
         in_q.push_back(stream_data_i);
         in_cyc.push_back(cycle);
      end
      if (stream_valid_o) begin
         out_q.push_back(stream_data_o);
         out_cyc.push_back(cycle);
      end
      if (state_o == delay_pkg::SEQ_DONE)
         done_count++;
   end

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         error_count++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp) begin
         error_count++;
         $display("Error %s: expected resp %b, actual resp %b", name, exp, act);
      end
   endtask

   task automatic check_state(input string name, input delay_pkg::seq_state_t exp,
                              input delay_pkg::seq_state_t act);
      if (act !== exp) begin
         error_count++;
         $display("Error %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         error_count++;
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic configure(input int amount, input int length);
      axil_write(delay_pkg::REG_AMOUNT, DATA_W'(amount), resp);
      check_resp("amount write", OKAY, resp);
      axil_write(delay_pkg::REG_LENGTH, DATA_W'(length), resp);
      check_resp("length write", OKAY, resp);
   endtask

   task automatic start_run(input int length);
      in_q.delete();
      out_q.delete();
      in_cyc.delete();
      out_cyc.delete();
      done_before = done_count;
      sample_budget += length;
      axil_write(delay_pkg::REG_CONTROL, DATA_W'(1), resp);
      check_resp("start write", OKAY, resp);
   endtask

   task automatic wait_run();
      wait (done_count != done_before);
      // let the last output land in the model
      @(negedge clk);
      @(negedge clk);
   endtask

   // output k is input k and appears one cycle after input k+amount was taken
   task automatic check_run(input string name, input int amount, input int length);
      int exp_count;
      exp_count = (length > amount) ? length - amount : 0;
      check_count({name, " samples"}, length, in_q.size());
      check_count({name, " outputs"}, exp_count, out_q.size());
      if (in_q.size() == length && out_q.size() == exp_count) begin
         for (int k = 0; k < exp_count; k++) begin
            check_data(name, in_q[k], out_q[k]);
            check_count({name, " output cycle"}, in_cyc[k + amount] + 1, out_cyc[k]);
         end
      end
   endtask

   initial begin
      int limit;
      limit = 0;
      while (cycle <= limit) begin
         @(posedge clk);
         limit = 64 * sample_budget + 2000;
      end
      $display("Timeout: the tests did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      logic [DATA_W-1:0] wval;
      int amount;
      int length;
      clk = 1'b0;
      rst = 1'b1;
      awaddr_i = '0;
      awvalid_i = 1'b0;
      wdata_i = '0;
      wstrb_i = '0;
      wvalid_i = 1'b0;
      bready_i = 1'b0;
      araddr_i = '0;
      arvalid_i = 1'b0;
      rready_i = 1'b0;
      stream_data_i = '0;
      seed = 32'h710f;
      error_count = 0;
      protocol_errors = 0;
      sample_budget = 0;
      cycle = 0;
      done_count = 0;
      done_before = 0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      // reset values and unmapped offset
      axil_read(delay_pkg::REG_AMOUNT, rd_data, resp);
      check_data("reset amount", '0, rd_data);
      check_resp("reset amount", OKAY, resp);
      axil_read(delay_pkg::REG_LENGTH, rd_data, resp);
      check_data("reset length", '0, rd_data);
      check_resp("reset length", OKAY, resp);
      axil_read(delay_pkg::REG_STATUS, rd_data, resp);
      check_data("reset status", '0, rd_data);
      check_resp("reset status", OKAY, resp);
      check_state("reset state", delay_pkg::SEQ_IDLE, state_o);
      axil_read(AW'('h10), rd_data, resp);
      check_data("unmapped read", '0, rd_data);
      check_resp("unmapped read", SLVERR, resp);

      // register masking
      for (int i = 0; i < 4; i++) begin
         wval = $random(seed);
         axil_write(delay_pkg::REG_AMOUNT, wval, resp);
         axil_read(delay_pkg::REG_AMOUNT, rd_data, resp);
         check_data("amount mask", DATA_W'(wval[ADDR_W-1:0]), rd_data);
         wval = $random(seed);
         axil_write(delay_pkg::REG_LENGTH, wval, resp);
         axil_read(delay_pkg::REG_LENGTH, rd_data, resp);
         check_data("length mask", DATA_W'(wval[LENGTH_W-1:0]), rd_data);
      end
      wval = $random(seed);
      axil_write(delay_pkg::REG_CONTROL, wval & ~DATA_W'(1), resp);
      axil_read(delay_pkg::REG_CONTROL, rd_data, resp);
      check_data("control readback", '0, rd_data);
      check_resp("control readback", OKAY, resp);

      // zero delay
      length = 1 + {$random(seed)} % 200;
      configure(0, length);
      start_run(length);
      wait_run();
      check_run("zero delay", 0, length);

      // random amounts with every fourth length at or below the amount
      for (int r = 0; r < 20; r++) begin
         amount = {$random(seed)} % (2 ** ADDR_W);
         if (r % 4 == 3)
            length = {$random(seed)} % (amount + 1);
         else
            length = {$random(seed)} % 300;
         configure(amount, length);
         start_run(length);
         wait_run();
         check_run($sformatf("run %0d", r), amount, length);
      end

      // writes while busy are ignored
      configure(5, 150);
      start_run(150);
      axil_read(delay_pkg::REG_STATUS, rd_data, resp);
      check_data("busy status", DATA_W'(1) << delay_pkg::STATUS_BUSY_BIT, rd_data);
      axil_write(delay_pkg::REG_AMOUNT, DATA_W'(9), resp);
      check_resp("busy amount write", OKAY, resp);
      axil_write(delay_pkg::REG_CONTROL, DATA_W'(1), resp);
      check_resp("busy start write", OKAY, resp);
      wait_run();
      check_run("busy run", 5, 150);
      axil_read(delay_pkg::REG_STATUS, rd_data, resp);
      check_data("done status", DATA_W'(1) << delay_pkg::STATUS_DONE_BIT, rd_data);
      axil_read(delay_pkg::REG_AMOUNT, rd_data, resp);
      check_data("amount kept", DATA_W'(5), rd_data);
      repeat (5) @(negedge clk);
      check_state("after busy run", delay_pkg::SEQ_IDLE, state_o);
      check_count("single run", done_before + 1, done_count);

      // back-to-back transactions under back-pressure
      for (int i = 0; i < 12; i++) begin
         wval = $random(seed);
         axil_write(delay_pkg::REG_LENGTH, wval, resp);
         check_resp("handshake write", OKAY, resp);
         axil_read(delay_pkg::REG_LENGTH, rd_data, resp);
         check_data("handshake read", DATA_W'(wval[LENGTH_W-1:0]), rd_data);
      end
      axil_write(AW'('h14), DATA_W'(1), resp);
      check_resp("unmapped write", SLVERR, resp);

      $display("Checks done: %0d value errors, %0d protocol errors",
               error_count, protocol_errors);
      if (error_count == 0 && protocol_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+verification
logic/delay_pkg.sv
logic/ram_port_if.sv
logic/dual_port_ram.sv
logic/sync_fifo.sv
logic/run_counter.sv
logic/run_sequencer.sv
logic/delay_buffer.sv
logic/axil_config_regs.sv
logic/delay_unit_top.sv
verification/delay_unit_tb.sv

//--- Makefile
# Verilator build of the delay unit testbench

VERILATOR ?= verilator
TOP       ?= delay_unit_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# status follows the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
